// File: rtl/degu_pkg.sv
package degu_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    localparam int unsigned ADW = 8;
    localparam int unsigned DW  = 8;

    ////////////////////
    // Host protocol
    ////////////////////

    // Frame start bytes
    localparam logic [DW-1:0] CMD_WRITE = 8'h57;
    localparam logic [DW-1:0] CMD_READ  = 8'h52;

    // Reply after a completed write
    localparam logic [DW-1:0] RSP_ACK   = 8'h4B;

    ////////////////////
    // Address map
    ////////////////////

    // Memory occupies everything below this
    localparam logic [ADW-1:0] MEM_TOP    = 8'h40;

    // GPIO registers
    localparam logic [ADW-1:0] ADR_GPIO_O = 8'h80;
    localparam logic [ADW-1:0] ADR_GPIO_E = 8'h81;
    localparam logic [ADW-1:0] ADR_GPIO_I = 8'h82;

endpackage: degu_pkg

// File: rtl/degu_bus_if.sv
interface degu_bus_if
    import degu_pkg::*;
();

    // Request side
    logic           req;
    logic           wen;
    logic [ADW-1:0] adr;
    logic [DW-1:0]  wdt;

    // Response side, one cycle after req
    logic [DW-1:0]  rdt;
    logic           ack;

    // UART bridge
    modport master (
        output req, wen, adr, wdt,
        input  rdt, ack
    );

    // Decode and peripherals
    modport slave (
        input  req, wen, adr, wdt,
        output rdt, ack
    );

endinterface: degu_bus_if

// File: rtl/degu_uart.sv
module degu_uart
    import degu_pkg::*;
#(
    parameter int unsigned BAUD_DIV = 234
)(
    input  logic          clk,
    input  logic          rst,
    // Serial lines
    output logic          txd,
    input  logic          rxd,
    // Receive strobe
    output logic          rx_vld,
    output logic [DW-1:0] rx_dat,
    // Transmit strobe
    input  logic          tx_vld,
    input  logic [DW-1:0] tx_dat,
    output logic          tx_bsy
);

    localparam int unsigned CW = $clog2(BAUD_DIV);

    // Receiver
    logic          rxd_m;
    logic          rxd_s;
    logic          rx_act;
    logic [CW-1:0] rx_cnt;
    logic [3:0]    rx_bit;
    logic [DW-1:0] rx_sft;

    // Transmitter
    logic          tx_act;
    logic [CW-1:0] tx_cnt;
    logic [3:0]    tx_bit;
    logic [DW:0]   tx_sft;

    ////////////////////
    // Receiver
    ////////////////////

    // Line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_m <= 1'b1;
            rxd_s <= 1'b1;
        end else begin
            rxd_m <= rxd;
            rxd_s <= rxd_m;
        end
    end

    // Bit 0 is start, 1..8 data, 9 stop
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_act <= 1'b0;
            rx_cnt <= '0;
            rx_bit <= '0;
            rx_vld <= 1'b0;
        end else begin
            rx_vld <= 1'b0;
            if (!rx_act) begin
                // Falling edge, wait half a bit to the middle
                if (!rxd_s) begin
                    rx_act <= 1'b1;
                    rx_cnt <= CW'(BAUD_DIV/2 - 1);
                    rx_bit <= '0;
                end
            end else if (rx_cnt != '0) begin
                rx_cnt <= rx_cnt - 1'b1;
            end else begin
                rx_cnt <= CW'(BAUD_DIV - 1);
                rx_bit <= rx_bit + 1'b1;
                if (rx_bit == 4'd0) begin
                    // Glitch, not a real start bit
                    if (rxd_s) begin
                        rx_act <= 1'b0;
                    end
                end else if (rx_bit == 4'd9) begin
                    rx_act <= 1'b0;
                    // Bad stop bit drops the frame
                    rx_vld <= rxd_s;
                end
            end
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (rx_act && rx_cnt == '0) begin
            if (rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
                rx_sft <= {rxd_s, rx_sft[DW-1:1]};
            end
            if (rx_bit == 4'd9) begin
                rx_dat <= rx_sft;
            end
        end
    end

    ////////////////////
    // Transmitter
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_act <= 1'b0;
            tx_cnt <= '0;
            tx_bit <= '0;
            txd    <= 1'b1;
        end else if (!tx_act) begin
            if (tx_vld) begin
                // Start bit goes out now
                tx_act <= 1'b1;
                tx_cnt <= CW'(BAUD_DIV - 1);
                tx_bit <= '0;
                txd    <= 1'b0;
            end
        end else if (tx_cnt != '0) begin
            tx_cnt <= tx_cnt - 1'b1;
        end else if (tx_bit == 4'd9) begin
            // Stop bit done
            tx_act <= 1'b0;
        end else begin
            tx_cnt <= CW'(BAUD_DIV - 1);
            tx_bit <= tx_bit + 1'b1;
            txd    <= tx_sft[0];
        end
    end

    // Data with stop bit on top, ones fill behind
    always_ff @(posedge clk) begin
        if (!tx_act && tx_vld) begin
            tx_sft <= {1'b1, tx_dat};
        end else if (tx_act && tx_cnt == '0) begin
            tx_sft <= {1'b1, tx_sft[DW:1]};
        end
    end

    assign tx_bsy = tx_act;

endmodule: degu_uart

// File: rtl/degu_uart_bridge.sv
module degu_uart_bridge
    import degu_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    // From UART receiver
    input  logic          rx_vld,
    input  logic [DW-1:0] rx_dat,
    // To UART transmitter
    output logic          tx_vld,
    output logic [DW-1:0] tx_dat,
    input  logic          tx_bsy,
    // Bus master
    degu_bus_if.master    bus
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADR,
        ST_DAT,
        ST_ACK,
        ST_RSP
    } state_t;

    state_t         state;
    logic           wen_r;
    logic [ADW-1:0] adr_r;
    logic [DW-1:0]  wdt_r;
    logic [DW-1:0]  rsp_r;

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            wen_r   <= 1'b0;
            bus.req <= 1'b0;
        end else begin
            // Request is a single pulse
            bus.req <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Anything else is dropped
                    if (rx_vld && rx_dat == CMD_WRITE) begin
                        wen_r <= 1'b1;
                        state <= ST_ADR;
                    end else if (rx_vld && rx_dat == CMD_READ) begin
                        wen_r <= 1'b0;
                        state <= ST_ADR;
                    end
                end
                ST_ADR: begin
                    if (rx_vld) begin
                        // Read frames end here
                        if (wen_r) begin
                            state <= ST_DAT;
                        end else begin
                            bus.req <= 1'b1;
                            state   <= ST_ACK;
                        end
                    end
                end
                ST_DAT: begin
                    if (rx_vld) begin
                        bus.req <= 1'b1;
                        state   <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (bus.ack) begin
                        state <= ST_RSP;
                    end
                end
                ST_RSP: begin
                    // Hold reply until transmitter frees up
                    if (tx_vld) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Frame fields and reply byte
    always_ff @(posedge clk) begin
        if (state == ST_ADR && rx_vld) begin
            adr_r <= rx_dat;
        end
        if (state == ST_DAT && rx_vld) begin
            wdt_r <= rx_dat;
        end
        if (state == ST_ACK && bus.ack) begin
            rsp_r <= wen_r ? RSP_ACK : bus.rdt;
        end
    end

    assign bus.wen = wen_r;
    assign bus.adr = adr_r;
    assign bus.wdt = wdt_r;

    assign tx_vld = (state == ST_RSP) && !tx_bsy;
    assign tx_dat = rsp_r;

endmodule: degu_uart_bridge

// File: rtl/degu_gpio.sv
module degu_gpio
    import degu_pkg::*;
#(
    parameter int unsigned GDW = 6
)(
    input  logic           clk,
    input  logic           rst,
    // Register access
    input  logic           sel,
    input  logic           wen,
    input  logic [1:0]     adr,
    input  logic [DW-1:0]  wdt,
    output logic [DW-1:0]  rdt,
    // Pins
    output logic [GDW-1:0] gpio_o,
    output logic [GDW-1:0] gpio_e,
    input  logic [GDW-1:0] gpio_i
);

    logic [GDW-1:0] gpio_m;
    logic [GDW-1:0] gpio_s;

    // Pins are asynchronous to clk
    always_ff @(posedge clk) begin
        gpio_m <= gpio_i;
        gpio_s <= gpio_m;
    end

    // Output and enable, input register is read only
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_o <= '0;
            gpio_e <= '0;
        end else if (sel && wen) begin
            if (adr == ADR_GPIO_O[1:0]) begin
                gpio_o <= wdt[GDW-1:0];
            end
            if (adr == ADR_GPIO_E[1:0]) begin
                gpio_e <= wdt[GDW-1:0];
            end
        end
    end

    // Registered read, upper bits zero
    always_ff @(posedge clk) begin
        if (sel && !wen) begin
            case (adr)
                ADR_GPIO_O[1:0]: rdt <= DW'(gpio_o);
                ADR_GPIO_E[1:0]: rdt <= DW'(gpio_e);
                ADR_GPIO_I[1:0]: rdt <= DW'(gpio_s);
                default:         rdt <= '0;
            endcase
        end
    end

endmodule: degu_gpio

// File: rtl/degu_mem.sv
module degu_mem
    import degu_pkg::*;
#(
    parameter int unsigned MEM_SIZ = 64
)(
    input  logic                       clk,
    input  logic                       sel,
    input  logic                       wen,
    input  logic [$clog2(MEM_SIZ)-1:0] adr,
    input  logic [DW-1:0]              wdt,
    output logic [DW-1:0]              rdt
);

    // Byte array
    logic [DW-1:0] mem [MEM_SIZ];

    // Write
    always_ff @(posedge clk) begin
        if (sel && wen) begin
            mem[adr] <= wdt;
        end
    end

    // Read data one cycle after select
    always_ff @(posedge clk) begin
        if (sel && !wen) begin
            rdt <= mem[adr];
        end
    end

endmodule: degu_mem

// File: rtl/degu_soc_top.sv
module degu_soc_top
    import degu_pkg::*;
#(
    parameter int unsigned GDW      = 6,
    parameter int unsigned MEM_SIZ  = 64,
    parameter int unsigned BAUD_DIV = 234
)(
    input  logic           clk,
    input  logic           rst,
    // GPIO
    output logic [GDW-1:0] gpio_o,
    output logic [GDW-1:0] gpio_e,
    input  logic [GDW-1:0] gpio_i,
    // UART
    output logic           uart_txd,
    input  logic           uart_rxd
);

    localparam int unsigned MAW = $clog2(MEM_SIZ);

    // UART strobes
    logic          rx_vld;
    logic [DW-1:0] rx_dat;
    logic          tx_vld;
    logic [DW-1:0] tx_dat;
    logic          tx_bsy;

    // Decode
    logic          mem_hit;
    logic          gpio_hit;
    logic          mem_rsel;
    logic          gpio_rsel;
    logic          ack_r;
    logic [DW-1:0] mem_rdt;
    logic [DW-1:0] gpio_rdt;

    degu_bus_if bus ();

    ////////////////////
    // Host side
    ////////////////////

    degu_uart #(
        .BAUD_DIV (BAUD_DIV)
    ) uart (
        .clk    (clk),
        .rst    (rst),
        .txd    (uart_txd),
        .rxd    (uart_rxd),
        .rx_vld (rx_vld),
        .rx_dat (rx_dat),
        .tx_vld (tx_vld),
        .tx_dat (tx_dat),
        .tx_bsy (tx_bsy)
    );

    degu_uart_bridge bridge (
        .clk    (clk),
        .rst    (rst),
        .rx_vld (rx_vld),
        .rx_dat (rx_dat),
        .tx_vld (tx_vld),
        .tx_dat (tx_dat),
        .tx_bsy (tx_bsy),
        .bus    (bus)
    );

    ////////////////////
    // Address decode
    ////////////////////

    // 0x83 is left unmapped
    assign mem_hit  = bus.adr < MEM_TOP;
    assign gpio_hit = (bus.adr[ADW-1:2] == ADR_GPIO_O[ADW-1:2]) && (bus.adr[1:0] != 2'd3);

    // Every access acked a cycle later, unmapped ones too
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_r     <= 1'b0;
            mem_rsel  <= 1'b0;
            gpio_rsel <= 1'b0;
        end else begin
            ack_r     <= bus.req;
            mem_rsel  <= bus.req && mem_hit;
            gpio_rsel <= bus.req && gpio_hit;
        end
    end

    assign bus.ack = ack_r;

    // Unmapped reads give zero
    assign bus.rdt = mem_rsel  ? mem_rdt  :
                     gpio_rsel ? gpio_rdt : '0;

    ////////////////////
    // Peripherals
    ////////////////////

    degu_mem #(
        .MEM_SIZ (MEM_SIZ)
    ) mem (
        .clk (clk),
        .sel (bus.req && mem_hit),
        .wen (bus.wen),
        .adr (bus.adr[MAW-1:0]),
        .wdt (bus.wdt),
        .rdt (mem_rdt)
    );

    degu_gpio #(
        .GDW (GDW)
    ) gpio (
        .clk    (clk),
        .rst    (rst),
        .sel    (bus.req && gpio_hit),
        .wen    (bus.wen),
        .adr    (bus.adr[1:0]),
        .wdt    (bus.wdt),
        .rdt    (gpio_rdt),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i)
    );

endmodule: degu_soc_top

// File: rtl/degu_soc_tangnano9k.sv
module degu_soc_tangnano9k #(
    parameter int unsigned MEM_SIZ  = 64,
    // 27MHz crystal, 115200 baud
    parameter int unsigned BAUD_DIV = 234
)(
    // Crystal
    input  logic       XTAL_IN,
    // Buttons, S[1] is reset
    input  logic [2:1] S,
    // LEDs
    output logic [6:1] LED,
    // UART
    output logic       FPGA_TX,
    input  logic       FPGA_RX
);

    localparam int unsigned GDW = $bits(LED);

    logic           clk;
    logic           rst_m;
    logic           rst;
    logic [GDW-1:0] gpio_o;
    logic [GDW-1:0] gpio_e;

    // No PLL, crystal runs the design
    assign clk = XTAL_IN;

    ////////////////////
    // Reset sync
    ////////////////////

    always_ff @(posedge clk) begin
        rst_m <= S[1];
        rst   <= rst_m;
    end

    ////////////////////
    // SoC
    ////////////////////

    // LED lit only where enabled and set
    assign LED = gpio_o & gpio_e;

    degu_soc_top #(
        .GDW      (GDW),
        .MEM_SIZ  (MEM_SIZ),
        .BAUD_DIV (BAUD_DIV)
    ) soc (
        .clk      (clk),
        .rst      (rst),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e),
        // Pin state read back
        .gpio_i   (LED),
        .uart_txd (FPGA_TX),
        .uart_rxd (FPGA_RX)
    );

endmodule: degu_soc_tangnano9k

// File: bench/degu_tb_clk.sv
module degu_tb_clk #(
    parameter int unsigned PERIOD = 100
)(
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ns;

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule: degu_tb_clk

// File: bench/degu_soc_assert.sv
module degu_soc_assert #(
    parameter int unsigned GDW = 6
)(
    input logic           clk,
    input logic           rst,
    // Bus handshake
    input logic           req,
    input logic           ack,
    // GPIO registers
    input logic [GDW-1:0] gpio_o,
    input logic [GDW-1:0] gpio_e
);

    timeunit 1ns;
    timeprecision 1ns;

    // Failed assertions, read by the testbench top
    int unsigned fail_cnt = 0;

    // Access in flight
    logic pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else if (req) begin
            pend <= 1'b1;
        end else if (ack) begin
            pend <= 1'b0;
        end
    end

    ////////////////////
    // Bus protocol
    ////////////////////

    // Ack exactly one cycle after req
    req_then_ack: assert property (@(posedge clk) disable iff (rst) req |=> ack)
        else begin
            fail_cnt++;
            $error("bus ack missing one cycle after req");
        end

    // No ack without a request before it
    ack_after_req: assert property (@(posedge clk) disable iff (rst) ack |-> $past(req))
        else begin
            fail_cnt++;
            $error("bus ack without a req in the cycle before");
        end

    // Single access in flight
    req_not_pending: assert property (@(posedge clk) disable iff (rst) req |-> !pend)
        else begin
            fail_cnt++;
            $error("bus req raised while an access is pending");
        end

    ////////////////////
    // GPIO reset
    ////////////////////

    gpio_reset_clear: assert property (@(posedge clk) rst |=> (gpio_o == '0 && gpio_e == '0))
        else begin
            fail_cnt++;
            $error("gpio_o or gpio_e not cleared after rst");
        end

endmodule: degu_soc_assert

bind degu_soc_top degu_soc_assert #(
    .GDW (GDW)
) i_assert (
    .clk    (clk),
    .rst    (rst),
    .req    (bus.req),
    .ack    (bus.ack),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e)
);

// File: bench/degu_tb.sv
module degu_tb
    import degu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int unsigned BAUD_DIV = 8;
    localparam int unsigned MEM_SIZ  = 64;
    // Reply wait limit in cycles
    localparam int          RSP_TMO  = 40 * BAUD_DIV;
    localparam int          N_WR     = 20;

    logic       clk;
    logic [2:1] s;
    logic [6:1] led;
    logic       fpga_tx;
    logic       fpga_rx;

    int          errors   = 0;
    int          timeouts = 0;
    logic [31:0] lfsr     = 32'hbf1706a6;

    // Host side model of memory
    logic [7:0] mem_model [MEM_SIZ];
    logic [5:0] wr_adr    [N_WR];

    degu_tb_clk #(
        .PERIOD (100)
    ) i_clk (
        .clk (clk)
    );

    degu_soc_tangnano9k #(
        .MEM_SIZ  (MEM_SIZ),
        .BAUD_DIV (BAUD_DIV)
    ) i_dut (
        .XTAL_IN (clk),
        .S       (s),
        .LED     (led),
        .FPGA_TX (fpga_tx),
        .FPGA_RX (fpga_rx)
    );

    ////////////////////
    // Random numbers
    ////////////////////

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] st);
        logic fb;
        fb = st[31] ^ st[21] ^ st[1] ^ st[0];
        return {st[30:0], fb};
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    ////////////////////
    // Checks and UART host
    ////////////////////

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        assert (got == exp) else begin
            errors++;
            $display("** Error at %0t ns: %s expected 8'h%02h, actual 8'h%02h",
                     $time, name, exp, got);
        end
    endtask

    // Called on a falling edge, returns on one
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            fpga_rx = frame[i];
            repeat (BAUD_DIV) @(negedge clk);
        end
    endtask

    // Samples each bit in its middle
    task automatic recv_byte(output logic [7:0] b, output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        b  = '0;
        while (fpga_tx && n < RSP_TMO) begin
            @(negedge clk);
            n++;
        end
        if (fpga_tx) begin
            timeouts++;
            $display("Timeout: no start bit on FPGA_TX within %0d cycles", RSP_TMO);
            return;
        end
        repeat (BAUD_DIV / 2) @(negedge clk);
        assert (!fpga_tx) else begin
            errors++;
            $display("Start bit on FPGA_TX ended before its middle");
        end
        // LSB first
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk);
            b[i] = fpga_tx;
        end
        repeat (BAUD_DIV) @(negedge clk);
        assert (fpga_tx) else begin
            errors++;
            $display("Stop bit on FPGA_TX is low");
        end
        ok = 1'b1;
    endtask

    task automatic write_reg(input logic [7:0] adr, input logic [7:0] dat);
        logic [7:0] rsp;
        logic       ok;
        send_byte(CMD_WRITE);
        send_byte(adr);
        send_byte(dat);
        recv_byte(rsp, ok);
        if (ok) begin
            check_byte($sformatf("FPGA_TX reply to write of 8'h%02h", adr), RSP_ACK, rsp);
        end
    endtask

    task automatic read_check(input logic [7:0] adr, input logic [7:0] exp);
        logic [7:0] rsp;
        logic       ok;
        send_byte(CMD_READ);
        send_byte(adr);
        recv_byte(rsp, ok);
        if (ok) begin
            check_byte($sformatf("FPGA_TX reply to read of 8'h%02h", adr), exp, rsp);
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic [31:0] r;
        logic [7:0]  dat;
        logic [5:0]  pat_o;
        logic [5:0]  pat_e;
        int unsigned afails;

        // Button pressed, line idle
        s       = 2'b01;
        fpga_rx = 1'b1;
        repeat (4) @(negedge clk);
        s[1] = 1'b0;
        // Two cycles through the synchronizer, plus margin
        repeat (4) @(negedge clk);

        // LEDs dark, registers clear
        check_byte("LED", 8'h00, {2'b00, led});
        read_check(ADR_GPIO_O, 8'h00);
        read_check(ADR_GPIO_E, 8'h00);

        // Random memory writes
        for (int i = 0; i < N_WR; i++) begin
            take_bits(6, r);
            wr_adr[i] = r[5:0];
            take_bits(8, r);
            dat = r[7:0];
            write_reg({2'b00, wr_adr[i]}, dat);
            mem_model[wr_adr[i]] = dat;
        end

        // Read back, last write wins
        for (int i = 0; i < N_WR; i++) begin
            read_check({2'b00, wr_adr[i]}, mem_model[wr_adr[i]]);
        end

        // LED shows output where enabled
        for (int k = 0; k < 3; k++) begin
            take_bits(6, r);
            pat_e = r[5:0];
            take_bits(6, r);
            pat_o = r[5:0];
            write_reg(ADR_GPIO_E, {2'b00, pat_e});
            write_reg(ADR_GPIO_O, {2'b00, pat_o});
            check_byte("LED", {2'b00, pat_o & pat_e}, {2'b00, led});
            // Pin state comes back as input
            read_check(ADR_GPIO_I, {2'b00, pat_o & pat_e});
        end

        // Unmapped space
        write_reg(8'h90, 8'h5A);
        read_check(8'h90, 8'h00);
        read_check(8'h83, 8'h00);
        read_check(8'h40, 8'h00);

        // Stray byte, then a normal read
        send_byte(8'hA5);
        read_check({2'b00, wr_adr[0]}, mem_model[wr_adr[0]]);

        afails = i_dut.soc.i_assert.fail_cnt;
        $display("errors %0d, assertion failures %0d, timeouts %0d",
                 errors, afails, timeouts);
        if (errors == 0 && timeouts == 0 && afails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule: degu_tb

// File: list.f
rtl/degu_pkg.sv
rtl/degu_bus_if.sv
rtl/degu_uart.sv
rtl/degu_uart_bridge.sv
rtl/degu_gpio.sv
rtl/degu_mem.sv
rtl/degu_soc_top.sv
rtl/degu_soc_tangnano9k.sv
bench/degu_tb_clk.sv
bench/degu_soc_assert.sv
bench/degu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Verilator build and run of the degu SoC testbench

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

# Compile
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module degu_tb -Mdir "$build_dir" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Run
"./$build_dir/Vdegu_tb" +verilator+error+limit+1000 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict from the log
if grep -qx "TEST RESULT: PASS" "$log_file"; then
    exit 0
fi
echo "Pass line not found in $log_file"
exit 1
